/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_jtag_debug -f src.f

run: compile
	-./obj_dir/Vtb_jtag_debug > run.log 2>&1
	cat run.log
	grep -q "Finished with no errors" run.log

clean:
	rm -rf obj_dir run.log

/* axi_lite_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface axi_lite_if
    import axi_lite_pkg::*;
    ();

    logic [AXI_ADDR_WIDTH-1:0] awaddr;
    logic awvalid;
    logic awready;

    logic [AXI_DATA_WIDTH-1:0] wdata;
    logic wvalid;
    logic wready;

    axi_resp_t bresp;
    logic bvalid;
    logic bready;

    logic [AXI_ADDR_WIDTH-1:0] araddr;
    logic arvalid;
    logic arready;

    logic [AXI_DATA_WIDTH-1:0] rdata;
    axi_resp_t rresp;
    logic rvalid;
    logic rready;

    modport master (
        output awaddr, awvalid, wdata, wvalid, bready, araddr, arvalid, rready,
        input awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

    modport slave (
        input awaddr, awvalid, wdata, wvalid, bready, araddr, arvalid, rready,
        output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );
endinterface

`default_nettype wire

/* axi_lite_pkg.sv */
`default_nettype none

package axi_lite_pkg;

    localparam int AXI_ADDR_WIDTH = 32;
    localparam int AXI_DATA_WIDTH = 32;

    // Only the two responses this subsystem produces are named
    typedef enum logic [1:0] {
        RESP_OKAY = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

endpackage

`default_nettype wire

/* axi_lite_reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_reg_bank
    import axi_lite_pkg::*;
#(
    parameter int NUM_REGS = 8
)
(
    input logic clk,
    input logic reset,
    axi_lite_if.slave axi,
    output logic [AXI_DATA_WIDTH-1:0] ctrl_out
);

    localparam int INDEX_WIDTH = $clog2(NUM_REGS);

    logic [AXI_DATA_WIDTH-1:0] regs [NUM_REGS];
    logic [INDEX_WIDTH-1:0] write_index;
    logic [INDEX_WIDTH-1:0] read_index;
    logic write_in_range;
    logic read_in_range;
    logic write_ready;
    logic read_ready;

    // Anything at or above NUM_REGS * 4 is out of range for the word-addressed bank
    assign write_index = axi.awaddr[INDEX_WIDTH+1:2];
    assign read_index = axi.araddr[INDEX_WIDTH+1:2];
    assign write_in_range = axi.awaddr[AXI_ADDR_WIDTH-1:INDEX_WIDTH+2] == '0;
    assign read_in_range = axi.araddr[AXI_ADDR_WIDTH-1:INDEX_WIDTH+2] == '0;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            write_ready <= 1'b0;
            read_ready <= 1'b0;
            axi.bvalid <= 1'b0;
            axi.rvalid <= 1'b0;
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else
        begin
            // Address and data are accepted together for a single cycle
            write_ready <= axi.awvalid && axi.wvalid && !write_ready && !axi.bvalid;
            read_ready <= axi.arvalid && !read_ready && !axi.rvalid;

            if (axi.awvalid && write_ready)
            begin
                axi.bvalid <= 1'b1;
                if (write_in_range)
                    regs[write_index] <= axi.wdata;
            end
            else if (axi.bready)
                axi.bvalid <= 1'b0;

            if (axi.arvalid && read_ready)
                axi.rvalid <= 1'b1;
            else if (axi.rready)
                axi.rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (axi.awvalid && write_ready)
            axi.bresp <= write_in_range ? RESP_OKAY : RESP_SLVERR;
        if (axi.arvalid && read_ready)
        begin
            axi.rresp <= read_in_range ? RESP_OKAY : RESP_SLVERR;
            axi.rdata <= read_in_range ? regs[read_index] : '0;
        end
    end

    assign axi.awready = write_ready;
    assign axi.wready = write_ready;
    assign axi.arready = read_ready;
    assign ctrl_out = regs[0];
endmodule

`default_nettype wire

/* jtag_axi_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module jtag_axi_bridge
    import jtag_pkg::*, axi_lite_pkg::*;
#(
    parameter logic [31:0] IDCODE_VALUE = 32'h1BAD_C0DE
)
(
    input logic clk,
    input logic reset,
    input logic [INSTRUCTION_WIDTH-1:0] instruction,
    input logic capture_dr,
    input logic shift_dr,
    input logic update_dr,
    input logic tdi,
    output logic data_shift_val,
    axi_lite_if.master axi
);

    localparam int MSB_WIDTH = $clog2(DATA_DR_WIDTH);

    logic [DATA_DR_WIDTH-1:0] shift_reg;
    logic [DATA_DR_WIDTH-1:0] shift_next;
    logic [MSB_WIDTH-1:0] dr_msb;
    logic [AXI_ADDR_WIDTH-1:0] addr_reg;
    logic [AXI_DATA_WIDTH-1:0] wdata_reg;
    logic [AXI_DATA_WIDTH-1:0] rdata_reg;
    logic write_flag;
    logic busy;
    logic error;
    logic op_write;
    logic is_addr;
    logic is_data;
    logic accept;
    logic start_read;
    logic start_write;

    assign is_addr = instruction == INSTR_AXI_ADDR;
    assign is_data = instruction == INSTR_AXI_DATA;

    // An update is only taken when nothing is in flight
    assign accept = update_dr && (is_addr || is_data) && !busy;
    assign start_read = accept && is_addr && !shift_reg[ADDR_DR_WIDTH-1];
    assign start_write = accept && is_data && write_flag;

    // Length of the selected register sets where TDI enters
    always_comb
    begin
        case (instruction)
            INSTR_IDCODE: dr_msb = MSB_WIDTH'(31);
            INSTR_AXI_ADDR: dr_msb = MSB_WIDTH'(ADDR_DR_WIDTH - 1);
            INSTR_AXI_DATA: dr_msb = MSB_WIDTH'(DATA_DR_WIDTH - 1);
            default: dr_msb = '0;
        endcase
        shift_next = shift_reg >> 1;
        shift_next[dr_msb] = tdi;
    end

    assign data_shift_val = shift_reg[0];

    always_ff @(posedge clk)
    begin
        if (capture_dr)
        begin
            case (instruction)
                INSTR_IDCODE: shift_reg <= DATA_DR_WIDTH'(IDCODE_VALUE);
                INSTR_AXI_ADDR: shift_reg <= {1'b0, write_flag, addr_reg};
                INSTR_AXI_DATA: shift_reg <= {busy, error, rdata_reg};
                default: shift_reg <= '0;
            endcase
        end
        else if (shift_dr)
            shift_reg <= shift_next;

        if (accept && is_addr)
            addr_reg <= shift_reg[AXI_ADDR_WIDTH-1:0];
        if (accept && is_data)
            wdata_reg <= shift_reg[AXI_DATA_WIDTH-1:0];
        if (axi.rvalid && axi.rready)
            rdata_reg <= axi.rdata;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            write_flag <= 1'b0;
            busy <= 1'b0;
            error <= 1'b0;
            op_write <= 1'b0;
            axi.awvalid <= 1'b0;
            axi.wvalid <= 1'b0;
            axi.arvalid <= 1'b0;
        end
        else
        begin
            if (accept && is_addr)
                write_flag <= shift_reg[ADDR_DR_WIDTH-1];

            if (start_write)
            begin
                busy <= 1'b1;
                op_write <= 1'b1;
                axi.awvalid <= 1'b1;
                axi.wvalid <= 1'b1;
            end
            else if (start_read)
            begin
                busy <= 1'b1;
                op_write <= 1'b0;
                axi.arvalid <= 1'b1;
            end

            // A request that collides with an active transaction is lost
            if (update_dr && (is_addr || is_data) && busy)
                error <= 1'b1;

            if (axi.awvalid && axi.awready)
                axi.awvalid <= 1'b0;
            if (axi.wvalid && axi.wready)
                axi.wvalid <= 1'b0;
            if (axi.arvalid && axi.arready)
                axi.arvalid <= 1'b0;

            if (axi.bvalid && axi.bready)
            begin
                busy <= 1'b0;
                error <= axi.bresp != RESP_OKAY;
            end
            if (axi.rvalid && axi.rready)
            begin
                busy <= 1'b0;
                error <= axi.rresp != RESP_OKAY;
            end
        end
    end

    assign axi.awaddr = addr_reg;
    assign axi.araddr = addr_reg;
    assign axi.wdata = wdata_reg;
    assign axi.bready = busy && op_write;
    assign axi.rready = busy && !op_write;
endmodule

`default_nettype wire

/* jtag_debug_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module jtag_debug_asserts
    import axi_lite_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic capture_dr,
    input logic update_dr,
    input logic awvalid,
    input logic awready,
    input logic [AXI_ADDR_WIDTH-1:0] awaddr,
    input logic wvalid,
    input logic wready,
    input logic [AXI_DATA_WIDTH-1:0] wdata,
    input logic bvalid,
    input logic arvalid,
    input logic arready,
    input logic [AXI_ADDR_WIDTH-1:0] araddr,
    input logic rvalid
);

    // Number of assertion failures so far, read by the testbench summary
    int failures = 0;

    // A raised valid holds with an unchanged payload until the slave takes it
    aw_hold: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else
        begin
            failures++;
            $error("awvalid dropped or awaddr changed before awready");
        end

    w_hold: assert property (@(posedge clk) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else
        begin
            failures++;
            $error("wvalid dropped or wdata changed before wready");
        end

    ar_hold: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else
        begin
            failures++;
            $error("arvalid dropped or araddr changed before arready");
        end

    // The bridge keeps only one transaction in flight
    one_outstanding: assert property (@(posedge clk) disable iff (reset)
        !((awvalid || wvalid || bvalid) && (arvalid || rvalid)))
        else
        begin
            failures++;
            $error("read and write transactions outstanding together");
        end

    strobes_apart: assert property (@(posedge clk) disable iff (reset)
        !(capture_dr && update_dr))
        else
        begin
            failures++;
            $error("capture_dr and update_dr fired in the same cycle");
        end
endmodule

bind jtag_axi_bridge jtag_debug_asserts jtag_debug_asserts_inst (
    .clk(clk),
    .reset(reset),
    .capture_dr(capture_dr),
    .update_dr(update_dr),
    .awvalid(axi.awvalid),
    .awready(axi.awready),
    .awaddr(axi.awaddr),
    .wvalid(axi.wvalid),
    .wready(axi.wready),
    .wdata(axi.wdata),
    .bvalid(axi.bvalid),
    .arvalid(axi.arvalid),
    .arready(axi.arready),
    .araddr(axi.araddr),
    .rvalid(axi.rvalid)
);

`default_nettype wire

/* jtag_debug_top.sv */
`timescale 1ns/1ps
`default_nettype none

module jtag_debug_top
    import jtag_pkg::*;
#(
    parameter logic [31:0] IDCODE_VALUE = 32'h1BAD_C0DE,
    parameter int NUM_REGS = 8
)
(
    input logic clk,
    input logic reset,
    input logic tck,
    input logic tms,
    input logic tdi,
    input logic trst,
    output logic tdo,
    output logic [31:0] ctrl_out
);

    jtag_if jtag_bus ();
    axi_lite_if axi_bus ();

    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic data_shift_val;
    logic [INSTRUCTION_WIDTH-1:0] instruction;

    assign jtag_bus.tck = tck;
    assign jtag_bus.tms = tms;
    assign jtag_bus.tdi = tdi;
    assign jtag_bus.trst = trst;
    assign tdo = jtag_bus.tdo;

    jtag_tap_controller jtag_tap_controller_inst (
        .clk(clk),
        .reset(reset),
        .jtag(jtag_bus.slave),
        .data_shift_val(data_shift_val),
        .capture_dr(capture_dr),
        .shift_dr(shift_dr),
        .update_dr(update_dr),
        .instruction(instruction)
    );

    jtag_axi_bridge #(
        .IDCODE_VALUE(IDCODE_VALUE)
    ) jtag_axi_bridge_inst (
        .clk(clk),
        .reset(reset),
        .instruction(instruction),
        .capture_dr(capture_dr),
        .shift_dr(shift_dr),
        .update_dr(update_dr),
        .tdi(tdi),
        .data_shift_val(data_shift_val),
        .axi(axi_bus.master)
    );

    axi_lite_reg_bank #(
        .NUM_REGS(NUM_REGS)
    ) axi_lite_reg_bank_inst (
        .clk(clk),
        .reset(reset),
        .axi(axi_bus.slave),
        .ctrl_out(ctrl_out)
    );
endmodule

`default_nettype wire

/* jtag_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Pins are assumed to be synchronous to the system clock already
interface jtag_if;
    logic tck;
    logic tms;
    logic tdi;
    logic trst;
    logic tdo;

    modport master (
        output tck, tms, tdi, trst,
        input tdo
    );

    modport slave (
        input tck, tms, tdi, trst,
        output tdo
    );
endinterface

`default_nettype wire

/* jtag_pkg.sv */
`default_nettype none

package jtag_pkg;

    // Sixteen TAP controller states, encoded in four bits
    typedef enum logic [3:0] {
        TAP_RESET,
        TAP_IDLE,
        TAP_SELECT_DR,
        TAP_CAPTURE_DR,
        TAP_SHIFT_DR,
        TAP_EXIT1_DR,
        TAP_PAUSE_DR,
        TAP_EXIT2_DR,
        TAP_UPDATE_DR,
        TAP_SELECT_IR,
        TAP_CAPTURE_IR,
        TAP_SHIFT_IR,
        TAP_EXIT1_IR,
        TAP_PAUSE_IR,
        TAP_EXIT2_IR,
        TAP_UPDATE_IR
    } jtag_state_t;

    localparam int INSTRUCTION_WIDTH = 4;

    // Any code not listed here selects the bypass register
    localparam logic [INSTRUCTION_WIDTH-1:0] INSTR_IDCODE = 4'h0;
    localparam logic [INSTRUCTION_WIDTH-1:0] INSTR_AXI_ADDR = 4'h2;
    localparam logic [INSTRUCTION_WIDTH-1:0] INSTR_AXI_DATA = 4'h3;
    localparam logic [INSTRUCTION_WIDTH-1:0] INSTR_BYPASS = 4'hF;

    // Write flag sits above the 32-bit address
    localparam int ADDR_DR_WIDTH = 33;

    // Busy and error sit above the 32-bit data word
    localparam int DATA_DR_WIDTH = 34;

endpackage

`default_nettype wire

/* jtag_tap_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module jtag_tap_controller
    import jtag_pkg::*;
(
    input logic clk,
    input logic reset,

    jtag_if.slave jtag,

    // Serial output of whichever data register the instruction selects
    input logic data_shift_val,
    output logic capture_dr,
    output logic shift_dr,
    output logic update_dr,
    output logic [INSTRUCTION_WIDTH-1:0] instruction
);

    jtag_state_t state_ff;
    jtag_state_t state_nxt;
    logic last_tck;
    logic tck_rising_edge;
    logic tck_falling_edge;

    // Standard IEEE 1149.1 state diagram, so five TMS ones reach reset from anywhere
    always_comb
    begin
        state_nxt = state_ff;
        case (state_ff)
            TAP_RESET:
                state_nxt = jtag.tms ? TAP_RESET : TAP_IDLE;
            TAP_IDLE:
                state_nxt = jtag.tms ? TAP_SELECT_DR : TAP_IDLE;

            TAP_SELECT_DR:
                state_nxt = jtag.tms ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR:
                state_nxt = jtag.tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR:
                state_nxt = jtag.tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR:
                state_nxt = jtag.tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:
                state_nxt = jtag.tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR:
                state_nxt = jtag.tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:
                state_nxt = jtag.tms ? TAP_SELECT_DR : TAP_IDLE;

            TAP_SELECT_IR:
                state_nxt = jtag.tms ? TAP_RESET : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR:
                state_nxt = jtag.tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR:
                state_nxt = jtag.tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR:
                state_nxt = jtag.tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:
                state_nxt = jtag.tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR:
                state_nxt = jtag.tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:
                state_nxt = jtag.tms ? TAP_SELECT_DR : TAP_IDLE;

            default:
                state_nxt = TAP_RESET;
        endcase
    end

    // TCK is sampled on clk, so an edge shows up one clk after the level changes
    assign tck_rising_edge = !last_tck && jtag.tck;
    assign tck_falling_edge = last_tck && !jtag.tck;

    // Strobes last the single clk in which the rising edge is seen
    assign capture_dr = tck_rising_edge && state_ff == TAP_CAPTURE_DR;
    assign shift_dr = tck_rising_edge && state_ff == TAP_SHIFT_DR;
    assign update_dr = tck_rising_edge && state_ff == TAP_UPDATE_DR;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state_ff <= TAP_RESET;
            last_tck <= 1'b0;
        end
        else
        begin
            last_tck <= jtag.tck;
            if (jtag.trst)
                state_ff <= TAP_RESET;
            else if (tck_rising_edge)
                state_ff <= state_nxt;
        end
    end

    // Instruction shifts in LSB first and falls back to IDCODE in Test-Logic-Reset
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            instruction <= INSTR_IDCODE;
        else if (state_ff == TAP_RESET)
            instruction <= INSTR_IDCODE;
        else if (tck_rising_edge && !jtag.trst && state_ff == TAP_SHIFT_IR)
            instruction <= {jtag.tdi, instruction[INSTRUCTION_WIDTH-1:1]};
    end

    // TDO changes on the falling edge so the host can sample it before the next rise
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            jtag.tdo <= 1'b0;
        else if (tck_falling_edge)
            jtag.tdo <= state_ff == TAP_SHIFT_IR ? instruction[0] : data_shift_val;
    end
endmodule

`default_nettype wire

/* src.f */
jtag_pkg.sv
axi_lite_pkg.sv
jtag_if.sv
axi_lite_if.sv
jtag_tap_controller.sv
jtag_axi_bridge.sv
axi_lite_reg_bank.sv
jtag_debug_top.sv
jtag_debug_asserts.sv
tb_jtag_debug.sv

/* tb_jtag_debug.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_jtag_debug
    import jtag_pkg::*;
();

    localparam logic [31:0] IDCODE_VALUE = 32'h1BAD_C0DE;
    localparam int NUM_REGS = 8;
    localparam int TCK_HALF_CLKS = 4;
    localparam logic [31:0] SEED = 32'h6f87_c401;
    // About 40 scans of about 90 TCK at 8 clk each, with margin
    localparam int TIMEOUT_CYCLES = 60000;

    logic clk;
    logic reset;
    logic tck;
    logic tms;
    logic tdi;
    logic trst;
    logic tdo;
    logic [31:0] ctrl_out;

    logic [31:0] model_regs [NUM_REGS];
    string name_q[$];
    logic [33:0] exp_q[$];
    logic [33:0] act_q[$];
    string cmp_name;
    logic [33:0] cmp_exp;
    logic [33:0] cmp_act;
    int check_count = 0;
    int error_count = 0;
    int test_checks = 0;
    int test_errors = 0;
    int cycle_count = 0;

    jtag_debug_top #(
        .IDCODE_VALUE(IDCODE_VALUE),
        .NUM_REGS(NUM_REGS)
    ) jtag_debug_top_inst (
        .clk(clk),
        .reset(reset),
        .tck(tck),
        .tms(tms),
        .tdi(tdi),
        .trst(trst),
        .tdo(tdo),
        .ctrl_out(ctrl_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Register bank model that returns {error, read data} and applies in-range writes
    function automatic logic [32:0] expected_access(input logic is_write,
                                                    input logic [31:0] addr,
                                                    input logic [31:0] data);
        int index;
        index = int'(addr >> 2);
        if (addr >= NUM_REGS * 4)
            return {1'b1, 32'h0};
        if (is_write)
        begin
            model_regs[index] = data;
            return {1'b0, 32'h0};
        end
        return {1'b0, model_regs[index]};
    endfunction

    task automatic queue_check(input string name, input logic [33:0] expected,
                               input logic [33:0] actual);
        name_q.push_back(name);
        exp_q.push_back(expected);
        act_q.push_back(actual);
    endtask

    always @(posedge clk)
    begin
        while (exp_q.size() > 0)
        begin
            cmp_name = name_q.pop_front();
            cmp_exp = exp_q.pop_front();
            cmp_act = act_q.pop_front();
            check_count++;
            assert (cmp_act === cmp_exp)
            else
            begin
                error_count++;
                $display("MISMATCH %s: expected %h, actual %h", cmp_name, cmp_exp, cmp_act);
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count == TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not end within %0d clk cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // One TCK period, low half first, with tdo read just before the rising edge
    task automatic tck_cycle(input logic tms_val, input logic tdi_val, output logic tdo_bit);
        tck = 1'b0;
        tms = tms_val;
        tdi = tdi_val;
        repeat (TCK_HALF_CLKS) @(posedge clk);
        #1;
        tdo_bit = tdo;
        tck = 1'b1;
        repeat (TCK_HALF_CLKS) @(posedge clk);
        #1;
    endtask

    task automatic goto_idle();
        logic unused;
        repeat (5) tck_cycle(1'b1, 1'b0, unused);
        tck_cycle(1'b0, 1'b0, unused);
    endtask

    task automatic pulse_trst();
        logic unused;
        trst = 1'b1;
        @(posedge clk);
        #1;
        trst = 1'b0;
        tck_cycle(1'b0, 1'b0, unused);
    endtask

    task automatic shift_ir(input logic [INSTRUCTION_WIDTH-1:0] code);
        logic unused;
        tck_cycle(1'b1, 1'b0, unused);
        tck_cycle(1'b1, 1'b0, unused);
        tck_cycle(1'b0, 1'b0, unused);
        tck_cycle(1'b0, 1'b0, unused);
        for (int i = 0; i < INSTRUCTION_WIDTH; i++)
            tck_cycle(i == INSTRUCTION_WIDTH - 1, code[i], unused);
        tck_cycle(1'b1, 1'b0, unused);
        tck_cycle(1'b0, 1'b0, unused);
    endtask

    // Idle to Idle DR scan that parks in Pause-DR after pause_at bits when pause_at is nonzero
    task automatic pause_shift_dr(input int n, input int pause_at, input logic [33:0] data_in,
                                  output logic [33:0] data_out);
        logic unused;
        logic bit_out;
        data_out = '0;
        tck_cycle(1'b1, 1'b0, unused);
        tck_cycle(1'b0, 1'b0, unused);
        tck_cycle(1'b0, 1'b0, unused);
        for (int i = 0; i < n; i++)
        begin
            tck_cycle(i == n - 1 || i == pause_at - 1, data_in[i], bit_out);
            data_out[i] = bit_out;
            if (i == pause_at - 1 && i != n - 1)
            begin
                tck_cycle(1'b0, 1'b0, unused);
                tck_cycle(1'b0, 1'b0, unused);
                tck_cycle(1'b1, 1'b0, unused);
                tck_cycle(1'b0, 1'b0, unused);
            end
        end
        tck_cycle(1'b1, 1'b0, unused);
        tck_cycle(1'b0, 1'b0, unused);
    endtask

    task automatic shift_dr(input int n, input logic [33:0] data_in, output logic [33:0] data_out);
        pause_shift_dr(n, 0, data_in, data_out);
    endtask

    task automatic write_reg(input string name, input logic [31:0] addr, input logic [31:0] data,
                             input int pause_at);
        logic [32:0] expected;
        logic [33:0] captured;
        expected = expected_access(1'b1, addr, data);
        shift_ir(INSTR_AXI_ADDR);
        pause_shift_dr(ADDR_DR_WIDTH, pause_at, {1'b0, 1'b1, addr}, captured);
        shift_ir(INSTR_AXI_DATA);
        pause_shift_dr(DATA_DR_WIDTH, pause_at, {2'b00, data}, captured);
        // Repeating the same write exposes the status of the first one
        pause_shift_dr(DATA_DR_WIDTH, pause_at, {2'b00, data}, captured);
        queue_check({name, " write status"}, {1'b0, expected[32], 32'h0},
                    {captured[33:32], 32'h0});
        queue_check({name, " ctrl_out"}, {2'b00, model_regs[0]}, {2'b00, ctrl_out});
    endtask

    task automatic read_reg(input string name, input logic [31:0] addr, input int pause_at);
        logic [32:0] expected;
        logic [33:0] captured;
        expected = expected_access(1'b0, addr, 32'h0);
        shift_ir(INSTR_AXI_ADDR);
        pause_shift_dr(ADDR_DR_WIDTH, pause_at, {2'b00, addr}, captured);
        shift_ir(INSTR_AXI_DATA);
        pause_shift_dr(DATA_DR_WIDTH, pause_at, 34'h0, captured);
        queue_check({name, " read"}, {1'b0, expected}, captured);
        queue_check({name, " ctrl_out"}, {2'b00, model_regs[0]}, {2'b00, ctrl_out});
    endtask

    task automatic end_test(input string name);
        do
            @(posedge clk);
        while (exp_q.size() != 0);
        #1;
        $display("Test %s: %0d checks, %0d errors", name, check_count - test_checks,
                 error_count - test_errors);
        test_checks = check_count;
        test_errors = error_count;
    endtask

    initial
    begin
        logic [33:0] captured;
        logic [31:0] pattern;
        void'($urandom(SEED));
        tck = 1'b0;
        tms = 1'b1;
        tdi = 1'b0;
        trst = 1'b0;
        reset = 1'b1;
        for (int i = 0; i < NUM_REGS; i++)
            model_regs[i] = 32'h0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        goto_idle();

        shift_dr(32, 34'h0, captured);
        queue_check("idcode", {2'b00, IDCODE_VALUE}, captured);
        end_test("idcode after reset");

        // The one-bit bypass register delays the pattern by one TCK
        shift_ir(INSTR_BYPASS);
        pattern = $urandom;
        shift_dr(16, {18'h0, pattern[15:0]}, captured);
        queue_check("bypass", {18'h0, pattern[14:0], 1'b0}, captured);
        shift_ir(4'h9);
        pattern = $urandom;
        shift_dr(16, {18'h0, pattern[15:0]}, captured);
        queue_check("unassigned code", {18'h0, pattern[14:0], 1'b0}, captured);
        end_test("bypass");

        write_reg("reg 0", 32'h0, $urandom, 0);
        repeat (5)
            write_reg("random reg", ($urandom % NUM_REGS) * 4, $urandom, 0);
        for (int i = 0; i < NUM_REGS; i++)
            read_reg($sformatf("reg %0d", i), i * 4, 0);
        end_test("register access");

        write_reg("out of range", NUM_REGS * 4, $urandom, 0);
        read_reg("out of range", NUM_REGS * 4, 0);
        read_reg("reg 0 after out of range", 32'h0, 0);
        end_test("out of range");

        shift_ir(INSTR_IDCODE);
        pause_shift_dr(32, 11, 34'h0, captured);
        queue_check("paused idcode", {2'b00, IDCODE_VALUE}, captured);
        write_reg("paused", 32'hC, $urandom, 9);
        read_reg("paused", 32'hC, 20);
        end_test("pause in scan");

        shift_ir(INSTR_BYPASS);
        pulse_trst();
        shift_dr(32, 34'h0, captured);
        queue_check("idcode after trst", {2'b00, IDCODE_VALUE}, captured);
        shift_ir(INSTR_BYPASS);
        goto_idle();
        shift_dr(32, 34'h0, captured);
        queue_check("idcode after tms reset", {2'b00, IDCODE_VALUE}, captured);
        end_test("tap reset");

        // Protocol assertions in the bridge count as errors too
        error_count += jtag_debug_top_inst.jtag_axi_bridge_inst.jtag_debug_asserts_inst.failures;
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end
endmodule

`default_nettype wire
